/* design/periph_consts.svh */
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// Bus widths
`define WB_AW 32
`define WB_DW 32
`define REG_OFF_W 12

// Address bits that pick one 4 KiB peripheral slot
`define SLOT_MSB 15
`define SLOT_LSB 12
`define SLOT_SOC_CTRL 4'd0
`define SLOT_GPIO 4'd1
`define SLOT_TIMER 4'd2

// Read pattern returned together with err
`define ERR_RDATA 32'hBADCAB1E
`define BOOT_ADDR_DEFAULT 32'h1000_0000
`define GPIO_COUNT 16
`define NUM_EXT_IRQS 4

// SoC control register offsets
`define SOC_CTRL_BOOTADDR 12'h000
`define SOC_CTRL_FETCHEN 12'h004

// GPIO register offsets
`define GPIO_DIR 12'h000
`define GPIO_OUT 12'h004
`define GPIO_IN 12'h008
`define GPIO_IRQ_EN 12'h00C
`define GPIO_IRQ_STATUS 12'h010

// Timer register offsets
`define TIMER_CTRL 12'h000
`define TIMER_COUNT 12'h004
`define TIMER_CMP 12'h008
`define TIMER_STATUS 12'h00C

`endif

/* design/periph_pkg.sv */
`include "periph_consts.svh"

package periph_pkg;

  typedef logic [`WB_AW-1:0]        wb_addr_t;
  typedef logic [`WB_DW-1:0]        wb_data_t;
  typedef logic [`WB_DW/8-1:0]      wb_sel_t;
  typedef logic [`REG_OFF_W-1:0]    reg_off_t;
  typedef logic [`GPIO_COUNT-1:0]   gpio_t;
  typedef logic [`NUM_EXT_IRQS-1:0] ext_irq_t;
  // Timer, GPIO, then the external lines
  typedef logic [`NUM_EXT_IRQS+1:0] irq_vec_t;

  // Manager to subordinate
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat;
    wb_sel_t  sel;
  } wb_req_t;

  // Subordinate to manager
  typedef struct packed {
    logic     ack;
    logic     err;
    wb_data_t dat;
  } wb_rsp_t;

  // Register access from the decoder to the units
  typedef struct packed {
    logic     wr;
    reg_off_t offset;
    wb_data_t wdata;
    wb_sel_t  sel;
  } reg_acc_t;

  // Expand the byte selects into a bit mask
  function automatic wb_data_t sel_mask(wb_sel_t sel);
    wb_data_t mask;
    for (int i = 0; i < `WB_DW/8; i++) begin
      mask[i*8 +: 8] = {8{sel[i]}};
    end
    return mask;
  endfunction

endpackage

/* design/periph_decode.sv */
`timescale 1ns/1ps
`include "periph_consts.svh"

module periph_decode (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  periph_pkg::wb_req_t  wb_req_i,
  output periph_pkg::wb_rsp_t  wb_rsp_o,
  output periph_pkg::reg_acc_t acc_o,
  output logic                 soc_ctrl_wr_o,
  output logic                 gpio_wr_o,
  output logic                 timer_wr_o,
  input  periph_pkg::wb_data_t soc_ctrl_rdata_i,
  input  periph_pkg::wb_data_t gpio_rdata_i,
  input  periph_pkg::wb_data_t timer_rdata_i
);

  logic [`SLOT_MSB:`SLOT_LSB] slot;
  logic                       accept;
  logic                       mapped;
  logic                       wr_accept;
  periph_pkg::wb_data_t       rdata_sel;
  logic                       ack_q;
  logic                       err_q;
  periph_pkg::wb_data_t       dat_q;

  // ------------------------------------------------------------
  // Accept and slot decode
  // ------------------------------------------------------------
  // No new request while a response is on the bus
  assign accept    = wb_req_i.cyc & wb_req_i.stb & ~ack_q & ~err_q;
  assign wr_accept = accept & wb_req_i.we;
  assign slot      = wb_req_i.adr[`SLOT_MSB:`SLOT_LSB];

  always_comb begin
    mapped    = 1'b1;
    rdata_sel = '0;
    case (slot)
      `SLOT_SOC_CTRL: rdata_sel = soc_ctrl_rdata_i;
      `SLOT_GPIO:     rdata_sel = gpio_rdata_i;
      `SLOT_TIMER:    rdata_sel = timer_rdata_i;
      default: begin
        mapped    = 1'b0;
        rdata_sel = `ERR_RDATA;
      end
    endcase
  end

  // Shared access fields, one strobe per unit
  assign acc_o.wr     = wb_req_i.we;
  assign acc_o.offset = wb_req_i.adr[`REG_OFF_W-1:0];
  assign acc_o.wdata  = wb_req_i.dat;
  assign acc_o.sel    = wb_req_i.sel;

  assign soc_ctrl_wr_o = wr_accept & (slot == `SLOT_SOC_CTRL);
  assign gpio_wr_o     = wr_accept & (slot == `SLOT_GPIO);
  assign timer_wr_o    = wr_accept & (slot == `SLOT_TIMER);

  // ------------------------------------------------------------
  // Response
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= accept & mapped;
      err_q <= accept & ~mapped;
    end
  end

  // Read word captured at the accepting edge
  always_ff @(posedge clk_i) begin
    if (accept) begin
      dat_q <= rdata_sel;
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.err = err_q;
  assign wb_rsp_o.dat = dat_q;

  // Exactly one response in the cycle after acceptance
  a_one_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    accept |=> (ack_q ^ err_q));

  // Never a response without a request before it
  a_no_spurious: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ack_q || err_q) |-> $past(accept));

endmodule

/* design/soc_ctrl_regs.sv */
`timescale 1ns/1ps
`include "periph_consts.svh"

module soc_ctrl_regs (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  periph_pkg::reg_acc_t acc_i,
  input  logic                 wr_i,
  output periph_pkg::wb_data_t rdata_o,
  input  logic                 fetch_en_i,
  output periph_pkg::wb_addr_t boot_addr_o,
  output logic                 fetch_enable_o
);

  periph_pkg::wb_addr_t boot_addr_q;
  periph_pkg::wb_data_t wmask;
  logic                 fetch_en_q;
  logic                 wr_en;

  assign wr_en = wr_i & acc_i.wr;
  assign wmask = periph_pkg::sel_mask(acc_i.sel);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      boot_addr_q <= `BOOT_ADDR_DEFAULT;
      fetch_en_q  <= 1'b0;
    end else if (wr_en) begin
      case (acc_i.offset)
        `SOC_CTRL_BOOTADDR: boot_addr_q <= (boot_addr_q & ~wmask) | (acc_i.wdata & wmask);
        `SOC_CTRL_FETCHEN: begin
          if (acc_i.sel[0]) begin
            fetch_en_q <= acc_i.wdata[0];
          end
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    rdata_o = '0;
    case (acc_i.offset)
      `SOC_CTRL_BOOTADDR: rdata_o    = boot_addr_q;
      `SOC_CTRL_FETCHEN:  rdata_o[0] = fetch_en_q;
      default: ;
    endcase
  end

  assign boot_addr_o = boot_addr_q;

  // Either the pin or software may start the core
  assign fetch_enable_o = fetch_en_q | fetch_en_i;

endmodule

/* design/gpio_unit.sv */
`timescale 1ns/1ps
`include "periph_consts.svh"

module gpio_unit (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  periph_pkg::reg_acc_t acc_i,
  input  logic                 wr_i,
  output periph_pkg::wb_data_t rdata_o,
  input  periph_pkg::gpio_t    gpio_i,
  output periph_pkg::gpio_t    gpio_o,
  output periph_pkg::gpio_t    gpio_out_en_o,
  output periph_pkg::gpio_t    gpio_in_sync_o,
  output logic                 irq_o
);

  periph_pkg::gpio_t    dir_q;
  periph_pkg::gpio_t    out_q;
  periph_pkg::gpio_t    irq_en_q;
  periph_pkg::gpio_t    status_q;
  periph_pkg::gpio_t    sync1_q;
  periph_pkg::gpio_t    sync2_q;
  periph_pkg::gpio_t    prev_q;
  periph_pkg::gpio_t    rise;
  periph_pkg::gpio_t    clr;
  periph_pkg::gpio_t    wmask_g;
  periph_pkg::gpio_t    wdata_g;
  periph_pkg::wb_data_t wmask;
  logic                 wr_en;

  assign wr_en   = wr_i & acc_i.wr;
  assign wmask   = periph_pkg::sel_mask(acc_i.sel);
  assign wmask_g = wmask[`GPIO_COUNT-1:0];
  assign wdata_g = acc_i.wdata[`GPIO_COUNT-1:0];

  // ------------------------------------------------------------
  // Input synchronizer and edge detect
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  assign rise = sync2_q & ~prev_q;

  // Write 1 to clear
  assign clr = (wr_en && acc_i.offset == `GPIO_IRQ_STATUS) ? (wdata_g & wmask_g) : '0;

  // ------------------------------------------------------------
  // Registers
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dir_q    <= '0;
      out_q    <= '0;
      irq_en_q <= '0;
      status_q <= '0;
    end else begin
      // A new edge wins over a clear in the same cycle
      status_q <= (status_q & ~clr) | (rise & irq_en_q);
      if (wr_en) begin
        case (acc_i.offset)
          `GPIO_DIR:    dir_q    <= (dir_q & ~wmask_g) | (wdata_g & wmask_g);
          `GPIO_OUT:    out_q    <= (out_q & ~wmask_g) | (wdata_g & wmask_g);
          `GPIO_IRQ_EN: irq_en_q <= (irq_en_q & ~wmask_g) | (wdata_g & wmask_g);
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    case (acc_i.offset)
      `GPIO_DIR:        rdata_o[`GPIO_COUNT-1:0] = dir_q;
      `GPIO_OUT:        rdata_o[`GPIO_COUNT-1:0] = out_q;
      `GPIO_IN:         rdata_o[`GPIO_COUNT-1:0] = sync2_q;
      `GPIO_IRQ_EN:     rdata_o[`GPIO_COUNT-1:0] = irq_en_q;
      `GPIO_IRQ_STATUS: rdata_o[`GPIO_COUNT-1:0] = status_q;
      default: ;
    endcase
  end

  assign gpio_o         = out_q;
  assign gpio_out_en_o  = dir_q;
  assign gpio_in_sync_o = sync2_q;
  assign irq_o          = |status_q;

  // Interrupt only comes up after an edge on an enabled pin
  a_irq_cause: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(irq_o) |-> $past(|(rise & irq_en_q)));

endmodule

/* design/timer_unit.sv */
`timescale 1ns/1ps
`include "periph_consts.svh"

module timer_unit (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  periph_pkg::reg_acc_t acc_i,
  input  logic                 wr_i,
  output periph_pkg::wb_data_t rdata_o,
  output logic                 irq_o
);

  periph_pkg::wb_data_t count_q;
  periph_pkg::wb_data_t count_d;
  periph_pkg::wb_data_t cmp_q;
  periph_pkg::wb_data_t wmask;
  logic                 en_q;
  logic                 autoclr_q;
  logic                 match_q;
  logic                 hit;
  logic                 wr_en;
  logic                 cnt_wr;
  logic                 match_clr;

  assign wr_en     = wr_i & acc_i.wr;
  assign wmask     = periph_pkg::sel_mask(acc_i.sel);
  assign cnt_wr    = wr_en && (acc_i.offset == `TIMER_COUNT);
  assign match_clr = wr_en && (acc_i.offset == `TIMER_STATUS) && acc_i.sel[0] && acc_i.wdata[0];
  assign hit       = en_q && (count_q == cmp_q);

  // ------------------------------------------------------------
  // Counter
  // ------------------------------------------------------------
  always_comb begin
    count_d = count_q;
    if (en_q) begin
      count_d = (hit && autoclr_q) ? '0 : count_q + 1'b1;
    end
    // Software write overrides the count
    if (cnt_wr) begin
      count_d = (count_q & ~wmask) | (acc_i.wdata & wmask);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q   <= '0;
      cmp_q     <= '0;
      en_q      <= 1'b0;
      autoclr_q <= 1'b0;
      match_q   <= 1'b0;
    end else begin
      count_q <= count_d;
      match_q <= (match_q & ~match_clr) | hit;
      if (wr_en && acc_i.offset == `TIMER_CTRL && acc_i.sel[0]) begin
        en_q      <= acc_i.wdata[0];
        autoclr_q <= acc_i.wdata[1];
      end
      if (wr_en && acc_i.offset == `TIMER_CMP) begin
        cmp_q <= (cmp_q & ~wmask) | (acc_i.wdata & wmask);
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    case (acc_i.offset)
      `TIMER_CTRL:   rdata_o[1:0] = {autoclr_q, en_q};
      `TIMER_COUNT:  rdata_o      = count_q;
      `TIMER_CMP:    rdata_o      = cmp_q;
      `TIMER_STATUS: rdata_o[0]   = match_q;
      default: ;
    endcase
  end

  assign irq_o = match_q;

  // Stopped counter holds unless software writes it
  a_count_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (!en_q && !cnt_wr) |=> $stable(count_q));

endmodule

/* design/periph_domain.sv */
`timescale 1ns/1ps
`include "periph_consts.svh"

module periph_domain (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  periph_pkg::wb_req_t  wb_req_i,
  output periph_pkg::wb_rsp_t  wb_rsp_o,
  input  logic                 fetch_en_i,
  output periph_pkg::wb_addr_t boot_addr_o,
  output logic                 fetch_enable_o,
  input  periph_pkg::gpio_t    gpio_i,
  output periph_pkg::gpio_t    gpio_o,
  output periph_pkg::gpio_t    gpio_out_en_o,
  output periph_pkg::gpio_t    gpio_in_sync_o,
  input  periph_pkg::ext_irq_t ext_irqs_i,
  output periph_pkg::irq_vec_t irqs_o
);

  periph_pkg::reg_acc_t acc;
  periph_pkg::wb_data_t soc_ctrl_rdata;
  periph_pkg::wb_data_t gpio_rdata;
  periph_pkg::wb_data_t timer_rdata;
  logic                 soc_ctrl_wr;
  logic                 gpio_wr;
  logic                 timer_wr;
  logic                 gpio_irq;
  logic                 timer_irq;

  // ------------------------------------------------------------
  // Bus decode
  // ------------------------------------------------------------
  periph_decode i_decode (
    .clk_i,
    .rst_n_i,
    .wb_req_i,
    .wb_rsp_o,
    .acc_o            ( acc            ),
    .soc_ctrl_wr_o    ( soc_ctrl_wr    ),
    .gpio_wr_o        ( gpio_wr        ),
    .timer_wr_o       ( timer_wr       ),
    .soc_ctrl_rdata_i ( soc_ctrl_rdata ),
    .gpio_rdata_i     ( gpio_rdata     ),
    .timer_rdata_i    ( timer_rdata    )
  );

  // ------------------------------------------------------------
  // Peripherals
  // ------------------------------------------------------------
  soc_ctrl_regs i_soc_ctrl (
    .clk_i,
    .rst_n_i,
    .acc_i          ( acc            ),
    .wr_i           ( soc_ctrl_wr    ),
    .rdata_o        ( soc_ctrl_rdata ),
    .fetch_en_i,
    .boot_addr_o,
    .fetch_enable_o
  );

  gpio_unit i_gpio (
    .clk_i,
    .rst_n_i,
    .acc_i          ( acc        ),
    .wr_i           ( gpio_wr    ),
    .rdata_o        ( gpio_rdata ),
    .gpio_i,
    .gpio_o,
    .gpio_out_en_o,
    .gpio_in_sync_o,
    .irq_o          ( gpio_irq   )
  );

  timer_unit i_timer (
    .clk_i,
    .rst_n_i,
    .acc_i   ( acc         ),
    .wr_i    ( timer_wr    ),
    .rdata_o ( timer_rdata ),
    .irq_o   ( timer_irq   )
  );

  // Timer in bit 0, GPIO in bit 1, external lines above
  assign irqs_o = {ext_irqs_i, gpio_irq, timer_irq};

endmodule

/* testbench/tb_periph_domain.sv */
`timescale 1ns/1ps
`include "periph_consts.svh"

module tb_periph_domain;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int MAX_POLLS      = 100;
  localparam logic [3:0] SLOT_UNMAPPED = 4'd5;

  logic                 clk_i;
  logic                 rst_n_i;
  periph_pkg::wb_req_t  wb_req;
  periph_pkg::wb_rsp_t  wb_rsp;
  logic                 fetch_en;
  periph_pkg::wb_addr_t boot_addr;
  logic                 fetch_enable;
  periph_pkg::gpio_t    gpio_in;
  periph_pkg::gpio_t    gpio_out;
  periph_pkg::gpio_t    gpio_out_en;
  periph_pkg::gpio_t    gpio_in_sync;
  periph_pkg::ext_irq_t ext_irqs;
  periph_pkg::irq_vec_t irqs;
  int                   errors;
  int                   checks;

  periph_domain i_dut (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .wb_req_i       ( wb_req       ),
    .wb_rsp_o       ( wb_rsp       ),
    .fetch_en_i     ( fetch_en     ),
    .boot_addr_o    ( boot_addr    ),
    .fetch_enable_o ( fetch_enable ),
    .gpio_i         ( gpio_in      ),
    .gpio_o         ( gpio_out     ),
    .gpio_out_en_o  ( gpio_out_en  ),
    .gpio_in_sync_o ( gpio_in_sync ),
    .ext_irqs_i     ( ext_irqs     ),
    .irqs_o         ( irqs         )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // Compare and report
  // ------------------------------------------------------------
  task automatic report_error(string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic check_data(string name, periph_pkg::wb_data_t exp, periph_pkg::wb_data_t act);
    checks++;
    if (act !== exp) report_error($sformatf("Fail %s: expected %h, got %h", name, exp, act));
  endtask

  task automatic check_gpio(string name, periph_pkg::gpio_t exp, periph_pkg::gpio_t act);
    checks++;
    if (act !== exp) report_error($sformatf("Fail %s: expected %h, got %h", name, exp, act));
  endtask

  task automatic check_irq(string name, periph_pkg::irq_vec_t exp, periph_pkg::irq_vec_t act);
    checks++;
    if (act !== exp) report_error($sformatf("Fail %s: expected %h, got %h", name, exp, act));
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    checks++;
    if (act !== exp) report_error($sformatf("Fail %s: expected %h, got %h", name, exp, act));
  endtask

  task automatic report_test(string name, int start_errors);
    $display("Test %s finished with %0d error(s)", name, errors - start_errors);
  endtask

  // Byte lanes with sel set take the new word
  function automatic periph_pkg::wb_data_t merge_bytes(periph_pkg::wb_data_t old_word,
                                                       periph_pkg::wb_data_t new_word,
                                                       periph_pkg::wb_sel_t sel);
    periph_pkg::wb_data_t res;
    res = old_word;
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) res[i*8 +: 8] = new_word[i*8 +: 8];
    end
    return res;
  endfunction

  function automatic periph_pkg::wb_addr_t slot_addr(logic [3:0] slot,
                                                     periph_pkg::reg_off_t off);
    return {16'h0000, slot, off};
  endfunction

  // ------------------------------------------------------------
  // Wishbone manager
  // ------------------------------------------------------------
  task automatic bus_cycle(input logic we, input periph_pkg::wb_addr_t adr,
                           input periph_pkg::wb_data_t dat, input periph_pkg::wb_sel_t sel,
                           input logic expect_err, output periph_pkg::wb_data_t rdata);
    int                  cycles;
    periph_pkg::wb_rsp_t rsp;
    cycles = 0;
    rsp    = '0;
    @(negedge clk_i);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
    wb_req.sel = sel;
    // Response registers are settled at the falling edge
    while (!(rsp.ack || rsp.err) && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      rsp = wb_rsp;
      cycles++;
    end
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
    rdata      = rsp.dat;
    checks++;
    if (!(rsp.ack || rsp.err)) begin
      report_error($sformatf("Timeout waiting for ack or err at address %h", adr));
    end else if (rsp.err && !expect_err) begin
      report_error($sformatf("Unexpected err at address %h", adr));
    end else if (rsp.ack && expect_err) begin
      report_error($sformatf("Missing err, ack came back at address %h", adr));
    end
  endtask

  task automatic wb_write(periph_pkg::wb_addr_t adr, periph_pkg::wb_data_t dat,
                          periph_pkg::wb_sel_t sel, logic expect_err);
    periph_pkg::wb_data_t unused_rdata;
    bus_cycle(1'b1, adr, dat, sel, expect_err, unused_rdata);
  endtask

  task automatic wb_read(input periph_pkg::wb_addr_t adr, input logic expect_err,
                         output periph_pkg::wb_data_t rdata);
    bus_cycle(1'b0, adr, '0, 4'hF, expect_err, rdata);
  endtask

  task automatic wait_in_sync(periph_pkg::gpio_t val);
    int cycles;
    cycles = 0;
    while (gpio_in_sync !== val && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      cycles++;
    end
    if (gpio_in_sync !== val) report_error("Timeout waiting for the synchronized GPIO inputs");
  endtask

  task automatic wait_irq_bit(int idx, logic val);
    int cycles;
    cycles = 0;
    while (irqs[idx] !== val && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      cycles++;
    end
    if (irqs[idx] !== val) report_error($sformatf("Timeout waiting for irqs_o bit %0d", idx));
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic test_reset_state();
    int                   start_errors;
    periph_pkg::wb_data_t rd;
    start_errors = errors;
    wb_read(slot_addr(`SLOT_SOC_CTRL, `SOC_CTRL_BOOTADDR), 1'b0, rd);
    check_data("BOOTADDR", `BOOT_ADDR_DEFAULT, rd);
    check_data("boot_addr_o", `BOOT_ADDR_DEFAULT, boot_addr);
    @(negedge clk_i);
    fetch_en = 1'b1;
    @(negedge clk_i);
    check_bit("fetch_enable_o", 1'b1, fetch_enable);
    fetch_en = 1'b0;
    @(negedge clk_i);
    check_bit("fetch_enable_o", 1'b0, fetch_enable);
    check_gpio("gpio_o", '0, gpio_out);
    check_gpio("gpio_out_en_o", '0, gpio_out_en);
    check_irq("irqs_o", '0, irqs);
    report_test("reset state", start_errors);
  endtask

  task automatic test_soc_ctrl();
    int                   start_errors;
    periph_pkg::wb_data_t rd;
    periph_pkg::wb_data_t boot;
    periph_pkg::wb_data_t update;
    periph_pkg::wb_sel_t  sel;
    start_errors = errors;
    boot = $urandom;
    wb_write(slot_addr(`SLOT_SOC_CTRL, `SOC_CTRL_BOOTADDR), boot, 4'hF, 1'b0);
    check_data("boot_addr_o", boot, boot_addr);
    update = $urandom;
    // Some lanes kept, some replaced
    sel    = $urandom_range(14, 1);
    wb_write(slot_addr(`SLOT_SOC_CTRL, `SOC_CTRL_BOOTADDR), update, sel, 1'b0);
    wb_read(slot_addr(`SLOT_SOC_CTRL, `SOC_CTRL_BOOTADDR), 1'b0, rd);
    check_data("BOOTADDR", merge_bytes(boot, update, sel), rd);
    check_data("boot_addr_o", merge_bytes(boot, update, sel), boot_addr);
    // Software start with the pin held low
    wb_write(slot_addr(`SLOT_SOC_CTRL, `SOC_CTRL_FETCHEN), 32'h1, 4'hF, 1'b0);
    check_bit("fetch_enable_o", 1'b1, fetch_enable);
    wb_read(slot_addr(`SLOT_SOC_CTRL, `SOC_CTRL_FETCHEN), 1'b0, rd);
    check_data("FETCHEN", 32'h1, rd);
    wb_write(slot_addr(`SLOT_SOC_CTRL, `SOC_CTRL_FETCHEN), 32'h0, 4'hF, 1'b0);
    check_bit("fetch_enable_o", 1'b0, fetch_enable);
    report_test("soc control", start_errors);
  endtask

  task automatic test_unmapped();
    int                   start_errors;
    periph_pkg::wb_data_t rd;
    start_errors = errors;
    wb_read(slot_addr(SLOT_UNMAPPED, 12'h000), 1'b1, rd);
    check_data("err read data", `ERR_RDATA, rd);
    wb_write(slot_addr(SLOT_UNMAPPED, 12'h004), $urandom, 4'hF, 1'b1);
    // Hole inside a mapped slot is acked
    wb_write(slot_addr(`SLOT_GPIO, 12'h020), $urandom, 4'hF, 1'b0);
    wb_read(slot_addr(`SLOT_GPIO, 12'h020), 1'b0, rd);
    check_data("GPIO hole", 32'h0, rd);
    report_test("unmapped slot", start_errors);
  endtask

  task automatic test_gpio();
    int                   start_errors;
    int                   pin;
    periph_pkg::wb_data_t rd;
    periph_pkg::gpio_t    dir;
    periph_pkg::gpio_t    out;
    periph_pkg::gpio_t    in_val;
    periph_pkg::gpio_t    pin_mask;
    logic [31:0]          rnd;
    start_errors = errors;
    rnd = $urandom;
    dir = rnd[15:0];
    out = rnd[31:16];
    wb_write(slot_addr(`SLOT_GPIO, `GPIO_DIR), {16'h0000, dir}, 4'hF, 1'b0);
    wb_write(slot_addr(`SLOT_GPIO, `GPIO_OUT), {16'h0000, out}, 4'hF, 1'b0);
    check_gpio("gpio_out_en_o", dir, gpio_out_en);
    check_gpio("gpio_o", out, gpio_out);
    rnd = $urandom;
    in_val = rnd[15:0];
    @(negedge clk_i);
    gpio_in = in_val;
    wait_in_sync(in_val);
    check_gpio("gpio_in_sync_o", in_val, gpio_in_sync);
    wb_read(slot_addr(`SLOT_GPIO, `GPIO_IN), 1'b0, rd);
    check_data("IN", {16'h0000, in_val}, rd);
    // Edge interrupt on one random pin
    pin      = $urandom_range(15, 0);
    pin_mask = '0;
    pin_mask[pin] = 1'b1;
    @(negedge clk_i);
    gpio_in = in_val & ~pin_mask;
    wait_in_sync(in_val & ~pin_mask);
    wb_write(slot_addr(`SLOT_GPIO, `GPIO_IRQ_EN), {16'h0000, pin_mask}, 4'hF, 1'b0);
    @(negedge clk_i);
    gpio_in = in_val | pin_mask;
    wait_irq_bit(1, 1'b1);
    wb_read(slot_addr(`SLOT_GPIO, `GPIO_IRQ_STATUS), 1'b0, rd);
    check_data("IRQ_STATUS", {16'h0000, pin_mask}, rd);
    check_irq("irqs_o", 6'b000010, irqs);
    wb_write(slot_addr(`SLOT_GPIO, `GPIO_IRQ_STATUS), {16'h0000, pin_mask}, 4'hF, 1'b0);
    wb_read(slot_addr(`SLOT_GPIO, `GPIO_IRQ_STATUS), 1'b0, rd);
    check_data("IRQ_STATUS", 32'h0, rd);
    check_irq("irqs_o", 6'b000000, irqs);
    wb_write(slot_addr(`SLOT_GPIO, `GPIO_IRQ_EN), 32'h0, 4'hF, 1'b0);
    report_test("gpio", start_errors);
  endtask

  task automatic test_timer();
    int                   start_errors;
    int                   polls;
    periph_pkg::wb_data_t rd;
    periph_pkg::wb_data_t cmp;
    start_errors = errors;
    cmp = $urandom_range(40, 8);
    wb_write(slot_addr(`SLOT_TIMER, `TIMER_CMP), cmp, 4'hF, 1'b0);
    // Enable with auto-clear
    wb_write(slot_addr(`SLOT_TIMER, `TIMER_CTRL), 32'h3, 4'hF, 1'b0);
    polls = 0;
    rd    = '0;
    while (rd[0] !== 1'b1 && polls < MAX_POLLS) begin
      wb_read(slot_addr(`SLOT_TIMER, `TIMER_STATUS), 1'b0, rd);
      polls++;
    end
    if (rd[0] !== 1'b1) report_error("Timeout waiting for the timer match status");
    check_bit("irqs_o[0]", 1'b1, irqs[0]);
    wb_read(slot_addr(`SLOT_TIMER, `TIMER_COUNT), 1'b0, rd);
    checks++;
    if (!(rd < cmp)) report_error($sformatf("Fail COUNT: expected below %h, got %h", cmp, rd));
    // Stop first so no new match races the clear
    wb_write(slot_addr(`SLOT_TIMER, `TIMER_CTRL), 32'h0, 4'hF, 1'b0);
    wb_write(slot_addr(`SLOT_TIMER, `TIMER_STATUS), 32'h1, 4'hF, 1'b0);
    check_bit("irqs_o[0]", 1'b0, irqs[0]);
    wb_read(slot_addr(`SLOT_TIMER, `TIMER_STATUS), 1'b0, rd);
    check_data("STATUS", 32'h0, rd);
    report_test("timer", start_errors);
  endtask

  task automatic test_ext_irqs();
    int          start_errors;
    logic [31:0] rnd;
    start_errors = errors;
    repeat (8) begin
      rnd = $urandom;
      @(negedge clk_i);
      ext_irqs = rnd[3:0];
      @(negedge clk_i);
      check_irq("irqs_o", {rnd[3:0], 2'b00}, irqs);
    end
    @(negedge clk_i);
    ext_irqs = '0;
    report_test("external interrupts", start_errors);
  endtask

  initial begin
    errors   = 0;
    checks   = 0;
    void'($urandom(2221));
    rst_n_i  = 1'b0;
    wb_req   = '0;
    fetch_en = 1'b0;
    gpio_in  = '0;
    ext_irqs = '0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    test_reset_state();
    test_soc_ctrl();
    test_unmapped();
    test_gpio();
    test_timer();
    test_ext_irqs();
    $display("Checks run: %0d, failures: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+design
design/periph_pkg.sv
design/periph_decode.sv
design/soc_ctrl_regs.sv
design/gpio_unit.sv
design/timer_unit.sv
design/periph_domain.sv
testbench/tb_periph_domain.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_periph_domain
FILELIST = verilog.f
BUILD    = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "No errors"

clean:
	rm -rf $(BUILD)
